//--- build.f
+incdir+include
design/hough_pkg.sv
design/edge_image_buffer.sv
design/rho_binner.sv
design/hough_accumulator.sv
design/peak_tracker.sv
design/hough_sequencer.sv
design/hough_top.sv
dv/hough_props.sv
dv/hough_checker.sv
dv/hough_tb.sv

//--- Bender.yml
package:
  name: hough_line_detector

sources:
  - include_dirs:
      - include
    files:
      - design/hough_pkg.sv
      - design/edge_image_buffer.sv
      - design/rho_binner.sv
      - design/hough_accumulator.sv
      - design/peak_tracker.sv
      - design/hough_sequencer.sv
      - design/hough_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/hough_props.sv
      - dv/hough_checker.sv
      - dv/hough_tb.sv

//--- dv/hough_tb.sv
// Runs a fixed image list through the core; the checker derives every expected result
`include "hough_params.svh"

module hough_tb;

    import hough_pkg::*;

    localparam int          CLK_PERIOD   = 100;
    localparam int          DRIVE_DELAY  = 5;       // Inputs change after the edge
    localparam int          DONE_TIMEOUT = 10000;   // Cycles, a run needs under 5000
    localparam int          NUM_TESTS    = 8;
    localparam logic [31:0] SEED         = 32'd48466;

    localparam int IMG_EMPTY  = 0;
    localparam int IMG_VLINE  = 1;   // x = 5
    localparam int IMG_HLINE  = 2;   // y = 9
    localparam int IMG_DIAG   = 3;
    localparam int IMG_RANDOM = 4;   // About 1 in 8 pixels
    localparam int IMG_ALL    = 5;

    // Name, image kind and whether out-of-range writes follow the image
    string table_name [NUM_TESTS] = '{"empty", "vertical_x5", "horizontal_y9", "diagonal",
                                      "random_a", "all_edges", "random_b", "empty_again"};
    int    table_kind [NUM_TESTS] = '{IMG_EMPTY, IMG_VLINE, IMG_HLINE, IMG_DIAG,
                                      IMG_RANDOM, IMG_ALL, IMG_RANDOM, IMG_EMPTY};
    logic  table_junk [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1};

    logic        clk;
    logic        reset_n;
    logic        start;
    logic        wr_en;
    logic [7:0]  wr_addr;
    logic [7:0]  wr_data;
    logic        busy;
    logic        done;
    line_field_t num_lines;
    line_field_t line_rho   [`HOUGH_MAX_LINES];
    line_field_t line_theta [`HOUGH_MAX_LINES];
    line_field_t line_votes [`HOUGH_MAX_LINES];
    int          test_id;
    int          pass_count;
    int          fail_count;
    int          timeouts;
    logic [7:0]  img [`HOUGH_IMG_BYTES];
    logic [31:0] rng;

    hough_top UUT (
        .clk(clk), .reset_n(reset_n), .start(start), .busy(busy), .done(done),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .num_lines(num_lines),
        .line_rho(line_rho), .line_theta(line_theta), .line_votes(line_votes)
    );

    hough_checker u_checker (
        .clk(clk), .reset_n(reset_n), .start(start), .busy(busy), .done(done),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .num_lines(num_lines),
        .line_rho(line_rho), .line_theta(line_theta), .line_votes(line_votes),
        .test_id(test_id), .pass_count(pass_count), .fail_count(fail_count)
    );

    bind hough_top hough_props u_props (
        .clk(clk), .reset_n(reset_n), .start(start), .busy(busy), .done(done),
        .num_lines(num_lines)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic build_image(input int kind);
        int   idx;
        logic px;
        for (int y = 0; y < `HOUGH_IMG_SIZE; y++) begin
            for (int x = 0; x < `HOUGH_IMG_SIZE; x++) begin
                case (kind)
                    IMG_VLINE: px = (x == 5);
                    IMG_HLINE: px = (y == 9);
                    IMG_DIAG:  px = (x == y);
                    IMG_ALL:   px = 1'b1;
                    IMG_RANDOM: begin
                        rng = xorshift(rng);
                        px  = (rng[2:0] == 3'd0);
                    end
                    default:   px = 1'b0;
                endcase
                idx = y * `HOUGH_IMG_SIZE + x;
                img[idx / 8][idx % 8] = px;   // LSB first within a byte
            end
        end
    endtask

    task automatic write_byte(input logic [7:0] addr, input logic [7:0] data);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(posedge clk);
        #DRIVE_DELAY;
        wr_en   = 1'b0;
    endtask

    task automatic load_image(input logic junk);
        for (int b = 0; b < `HOUGH_IMG_BYTES; b++) begin
            write_byte(8'(b), img[b]);
        end
        if (junk) begin
            write_byte(8'd32, 8'hFF);   // Would alias onto byte 0
            write_byte(8'hFF, 8'hFF);   // Would alias onto byte 31
        end
    endtask

    task automatic wait_for_done(output logic seen);
        seen = 1'b0;
        for (int n = 0; n < DONE_TIMEOUT && !seen; n++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            seen = done;
        end
    endtask

    initial begin
        logic got;
        int   failures;
        reset_n  = 1'b0;
        start    = 1'b0;
        wr_en    = 1'b0;
        wr_addr  = 8'h00;
        wr_data  = 8'h00;
        test_id  = 0;
        timeouts = 0;
        rng      = SEED;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY reset_n = 1'b1;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_id = t + 1;
            $display("Test %0d starts: %s", test_id, table_name[t]);
            build_image(table_kind[t]);
            load_image(table_junk[t]);
            start = 1'b1;
            @(posedge clk);
            #DRIVE_DELAY start = 1'b0;
            wait_for_done(got);
            if (!got) begin
                $display("Test %0d timed out waiting for done", test_id);
                timeouts++;
            end
            @(posedge clk);   // Checker compares on this edge
            #DRIVE_DELAY;
        end
        repeat (2) @(posedge clk);
        failures = fail_count + timeouts + UUT.u_props.assert_fails;
        $display("Tests passed: %0d, failed: %0d", pass_count, failures);
        if (failures == 0 && pass_count == NUM_TESTS + 1) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- dv/hough_checker.sv
// Reference model and scoreboard; assumes the image is only written while the core is idle
`include "hough_params.svh"

module hough_checker (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   start,
    input  logic                   busy,
    input  logic                   done,
    input  logic                   wr_en,
    input  logic [7:0]             wr_addr,
    input  logic [7:0]             wr_data,
    input  hough_pkg::line_field_t num_lines,
    input  hough_pkg::line_field_t line_rho   [`HOUGH_MAX_LINES],
    input  hough_pkg::line_field_t line_theta [`HOUGH_MAX_LINES],
    input  hough_pkg::line_field_t line_votes [`HOUGH_MAX_LINES],
    input  int                     test_id,
    output int                     pass_count,
    output int                     fail_count
);

    import hough_pkg::*;

    // sin and cos times 256, one entry per 11.25 degree step
    localparam int SIN_TAB [16] = '{0, 50, 98, 142, 181, 213, 237, 251,
                                    256, 251, 237, 213, 181, 142, 98, 50};
    localparam int COS_TAB [16] = '{256, 251, 237, 213, 181, 142, 98, 50,
                                    0, -50, -98, -142, -181, -213, -237, -251};

    logic [7:0] image [`HOUGH_IMG_BYTES];   // Shadow copy of the written bytes
    int   acc [`HOUGH_ACC_CELLS];
    int   exp_count;
    int   exp_rho [`HOUGH_MAX_LINES];
    int   exp_theta [`HOUGH_MAX_LINES];
    int   exp_votes [`HOUGH_MAX_LINES];
    int   errors;
    logic armed;          // Start seen, waiting for done
    logic reset_checked;

    initial begin
        pass_count    = 0;
        fail_count    = 0;
        reset_checked = 1'b0;
    end

    // Votes with saturation, then the top-4 selection in scan order
    task automatic run_model();
        int idx;
        int rho;
        int slot;
        for (int c = 0; c < `HOUGH_ACC_CELLS; c++) begin
            acc[c] = 0;
        end
        for (int y = 0; y < `HOUGH_IMG_SIZE; y++) begin
            for (int x = 0; x < `HOUGH_IMG_SIZE; x++) begin
                idx = y * `HOUGH_IMG_SIZE + x;
                if (image[idx / 8][idx % 8]) begin
                    for (int t = 0; t < `HOUGH_THETA_BINS; t++) begin
                        rho = (x * COS_TAB[t] + y * SIN_TAB[t]) / (1 << `HOUGH_TRIG_SHIFT);
                        rho = (rho < 0) ? 0 : ((rho >= `HOUGH_RHO_BINS) ? 15 : rho);
                        if (acc[rho * `HOUGH_THETA_BINS + t] < `HOUGH_VOTE_MAX) begin
                            acc[rho * `HOUGH_THETA_BINS + t]++;
                        end
                    end
                end
            end
        end
        exp_count = 0;
        for (int i = 0; i < `HOUGH_MAX_LINES; i++) begin
            exp_rho[i]   = 0;
            exp_theta[i] = 0;
            exp_votes[i] = 0;
        end
        // Cell order is rho outer, theta inner
        for (int c = 0; c < `HOUGH_ACC_CELLS; c++) begin
            slot = -1;
            if (acc[c] >= `HOUGH_VOTE_THRESHOLD && exp_count < `HOUGH_MAX_LINES) begin
                slot = exp_count;
                exp_count++;
            end else if (acc[c] >= `HOUGH_VOTE_THRESHOLD) begin
                slot = 0;   // First minimum wins
                for (int i = 1; i < `HOUGH_MAX_LINES; i++) begin
                    if (exp_votes[i] < exp_votes[slot]) begin
                        slot = i;
                    end
                end
                if (acc[c] <= exp_votes[slot]) begin
                    slot = -1;   // Must be strictly stronger
                end
            end
            if (slot >= 0) begin
                exp_rho[slot]   = c / `HOUGH_THETA_BINS;
                exp_theta[slot] = (c % `HOUGH_THETA_BINS) * `HOUGH_THETA_SPAN / `HOUGH_THETA_BINS;
                exp_votes[slot] = acc[c];
            end
        end
    endtask

    task automatic check_field(input string name, input int exp_val, input logic [7:0] act);
        if (act !== 8'(exp_val)) begin
            $display("ERROR test %0d %s expected 0x%02h actual 0x%02h",
                     test_id, name, 8'(exp_val), act);
            errors++;
        end
    endtask

    task automatic check_results();
        check_field("num_lines", exp_count, num_lines);
        for (int i = 0; i < `HOUGH_MAX_LINES; i++) begin
            check_field($sformatf("line_rho[%0d]", i), exp_rho[i], line_rho[i]);
            check_field($sformatf("line_theta[%0d]", i), exp_theta[i], line_theta[i]);
            check_field($sformatf("line_votes[%0d]", i), exp_votes[i], line_votes[i]);
        end
    endtask

    task automatic close_test(input string what);
        if (errors == 0) begin
            pass_count++;
            $display("Test %0d %s: PASS", test_id, what);
        end else begin
            fail_count++;
            $display("Test %0d %s: FAIL with %0d mismatches", test_id, what, errors);
        end
    endtask

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `HOUGH_IMG_BYTES; i++) begin
                image[i] = 8'h00;   // Core image clears on reset too
            end
            armed = 1'b0;
        end else begin
            if (!reset_checked) begin
                errors = 0;
                run_model();   // Blank image gives all-zero results
                check_results();
                check_field("busy", 0, {7'b0, busy});
                check_field("done", 0, {7'b0, done});
                close_test("reset");
                reset_checked = 1'b1;
            end
            if (wr_en && wr_addr < `HOUGH_IMG_BYTES) begin
                image[wr_addr] = wr_data;
            end
            if (armed && done) begin
                run_model();
                check_results();
                close_test("run");
                armed = 1'b0;
            end else if (armed && !busy) begin
                $display("Test %0d: busy fell before done arrived", test_id);
                fail_count++;
                armed = 1'b0;
            end else if (done) begin
                $display("Test %0d: done pulsed with no run in progress", test_id);
                fail_count++;
            end
            if (start && !busy && !armed) begin
                armed  = 1'b1;   // Busy must hold from the next edge
                errors = 0;
            end
        end
    end

endmodule

//--- dv/hough_props.sv
// Control checks bound into hough_top; they are disabled while reset_n is low
`include "hough_params.svh"

module hough_props (
    input logic                   clk,
    input logic                   reset_n,
    input logic                   start,
    input logic                   busy,
    input logic                   done,
    input hough_pkg::line_field_t num_lines
);

    int assert_fails = 0;   // Failure tally

    // busy falls on the same edge that raises done
    done_busy_exclusive: assert property (@(posedge clk) disable iff (!reset_n) !(done && busy))
        else begin
            $error("done and busy are high in the same cycle");
            assert_fails++;
        end

    done_single_cycle: assert property (@(posedge clk) disable iff (!reset_n) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            assert_fails++;
        end

    lines_in_range: assert property (@(posedge clk) disable iff (!reset_n)
        num_lines <= `HOUGH_MAX_LINES)
        else begin
            $error("num_lines exceeds the slot count");
            assert_fails++;
        end

    // Idle is the only state with busy low
    start_raises_busy: assert property (@(posedge clk) disable iff (!reset_n)
        (start && !busy) |=> busy)
        else begin
            $error("busy did not rise the cycle after start");
            assert_fails++;
        end

endmodule

//--- design/hough_top.sv
// Hough line detector top; load the 32 image bytes while idle, then pulse start and wait for done
`include "hough_params.svh"

module hough_top (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   start,
    output logic                   busy,
    output logic                   done,
    input  logic                   wr_en,
    input  logic [7:0]             wr_addr,
    input  logic [7:0]             wr_data,
    output hough_pkg::line_field_t num_lines,
    output hough_pkg::line_field_t line_rho   [`HOUGH_MAX_LINES],
    output hough_pkg::line_field_t line_theta [`HOUGH_MAX_LINES],
    output hough_pkg::line_field_t line_votes [`HOUGH_MAX_LINES]
);

    import hough_pkg::*;

    // Sequencer to image path
    coord_t     pixel_x;
    coord_t     pixel_y;
    theta_idx_t theta_idx;
    logic       edge_bit;
    rho_bin_t   rho_bin;

    // Accumulator port
    acc_addr_t  acc_addr;
    logic       acc_clear;
    logic       acc_incr;
    vote_t      acc_votes;

    // Scan stream into the tracker
    logic       track_clear;
    logic       scan_valid;
    rho_bin_t   scan_rho;
    theta_idx_t scan_theta;

    edge_image_buffer u_image (
        .clk(clk), .reset_n(reset_n), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .pixel_x(pixel_x), .pixel_y(pixel_y), .edge_bit(edge_bit)
    );

    rho_binner u_rho (
        .pixel_x(pixel_x), .pixel_y(pixel_y), .theta_idx(theta_idx), .rho_bin(rho_bin)
    );

    hough_accumulator u_acc (
        .clk(clk), .acc_addr(acc_addr), .acc_clear(acc_clear), .acc_incr(acc_incr),
        .acc_votes(acc_votes)
    );

    // Tracker count is the line count seen by the host
    peak_tracker u_peaks (
        .clk(clk), .reset_n(reset_n), .track_clear(track_clear), .scan_valid(scan_valid),
        .scan_rho(scan_rho), .scan_theta(scan_theta), .acc_votes(acc_votes),
        .line_count(num_lines), .line_rho(line_rho), .line_theta(line_theta),
        .line_votes(line_votes)
    );

    hough_sequencer u_seq (
        .clk(clk), .reset_n(reset_n), .start(start), .busy(busy), .done(done),
        .pixel_x(pixel_x), .pixel_y(pixel_y), .theta_idx(theta_idx),
        .edge_bit(edge_bit), .rho_bin(rho_bin),
        .acc_addr(acc_addr), .acc_clear(acc_clear), .acc_incr(acc_incr),
        .track_clear(track_clear), .scan_valid(scan_valid),
        .scan_rho(scan_rho), .scan_theta(scan_theta)
    );

endmodule

//--- design/hough_sequencer.sv
// Run control; start is taken only in IDLE and a run takes a fixed 4611 cycles from start to done
`include "hough_params.svh"

module hough_sequencer (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     start,        // Pulse, ignored while busy
    output logic                     busy,
    output logic                     done,         // One-cycle pulse
    output hough_pkg::coord_t        pixel_x,      // Doubles as rho during the scan
    output hough_pkg::coord_t        pixel_y,      // Doubles as theta during the scan
    output hough_pkg::theta_idx_t    theta_idx,
    input  logic                     edge_bit,
    input  hough_pkg::rho_bin_t      rho_bin,
    output hough_pkg::acc_addr_t     acc_addr,
    output logic                     acc_clear,
    output logic                     acc_incr,
    output logic                     track_clear,
    output logic                     scan_valid,
    output hough_pkg::rho_bin_t      scan_rho,
    output hough_pkg::theta_idx_t    scan_theta
);

    import hough_pkg::*;

    hough_state_t state;
    logic [$clog2(`HOUGH_ACC_CELLS):0] clear_count;  // One extra bit marks the end of the sweep
    logic clear_busy;
    logic last_theta;
    logic last_x;
    logic last_y;

    assign clear_busy = (clear_count < `HOUGH_ACC_CELLS);
    assign last_theta = (theta_idx == theta_idx_t'(`HOUGH_THETA_BINS - 1));
    assign last_x     = (pixel_x == coord_t'(`HOUGH_IMG_SIZE - 1));
    assign last_y     = (pixel_y == coord_t'(`HOUGH_IMG_SIZE - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= IDLE;
            busy        <= 1'b0;
            done        <= 1'b0;
            clear_count <= '0;
            pixel_x     <= '0;
            pixel_y     <= '0;
            theta_idx   <= '0;
        end else begin
            done <= 1'b0;   // Default low, set only in DONE_STATE
            case (state)
                IDLE: begin
                    if (start) begin
                        busy        <= 1'b1;
                        clear_count <= '0;
                        state       <= CLEAR_ACC;
                    end
                end
                CLEAR_ACC: begin
                    if (clear_busy) begin
                        clear_count <= clear_count + 1'b1;
                    end else begin
                        pixel_x   <= '0;   // Extra cycle to hand over to voting
                        pixel_y   <= '0;
                        theta_idx <= '0;
                        state     <= VOTE;
                    end
                end
                VOTE: begin
                    // Theta innermost, then x, then y
                    theta_idx <= theta_idx + 1'b1;
                    if (last_theta) begin
                        pixel_x <= pixel_x + 1'b1;
                        if (last_x) begin
                            pixel_y <= pixel_y + 1'b1;
                            if (last_y) state <= FIND_PEAKS;   // All counters wrap to 0
                        end
                    end
                end
                FIND_PEAKS: begin
                    // Theta inner on pixel_y, rho outer on pixel_x
                    pixel_y <= pixel_y + 1'b1;
                    if (pixel_y == coord_t'(`HOUGH_THETA_BINS - 1)) begin
                        pixel_x <= pixel_x + 1'b1;
                        if (pixel_x == coord_t'(`HOUGH_RHO_BINS - 1)) state <= DONE_STATE;
                    end
                end
                DONE_STATE: begin
                    done  <= 1'b1;
                    busy  <= 1'b0;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Accumulator address per phase
    always_comb begin
        case (state)
            CLEAR_ACC:  acc_addr = acc_addr_t'(clear_count);
            VOTE:       acc_addr = {rho_bin, theta_idx};   // rho*16+theta
            FIND_PEAKS: acc_addr = {pixel_x, pixel_y};
            default:    acc_addr = '0;
        endcase
    end

    assign acc_clear   = (state == CLEAR_ACC) && clear_busy;
    assign acc_incr    = (state == VOTE) && edge_bit;   // Only edge pixels vote
    assign track_clear = (state == IDLE) && start;      // Same edge as the state change
    assign scan_valid  = (state == FIND_PEAKS);
    assign scan_rho    = rho_bin_t'(pixel_x);
    assign scan_theta  = theta_idx_t'(pixel_y);

endmodule

//--- design/peak_tracker.sv
// Top-4 peak list; ties keep the earlier cell and a full list replaces only the lowest-index minimum
`include "hough_params.svh"

module peak_tracker (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     track_clear,   // Empties the list at run start
    input  logic                     scan_valid,    // Current cell is part of the scan
    input  hough_pkg::rho_bin_t      scan_rho,
    input  hough_pkg::theta_idx_t    scan_theta,
    input  hough_pkg::vote_t         acc_votes,
    output hough_pkg::line_field_t   line_count,
    output hough_pkg::line_field_t   line_rho   [`HOUGH_MAX_LINES],
    output hough_pkg::line_field_t   line_theta [`HOUGH_MAX_LINES],
    output hough_pkg::line_field_t   line_votes [`HOUGH_MAX_LINES]
);

    import hough_pkg::*;

    logic [$clog2(`HOUGH_MAX_LINES)-1:0] min_idx;   // Weakest slot, lowest index on ties
    logic [$clog2(`HOUGH_MAX_LINES)-1:0] wr_idx;    // Next free slot
    logic        hit;        // Cell reaches the threshold
    logic        has_room;
    logic        beats_min;  // Strictly stronger than the weakest slot
    line_field_t new_votes;
    line_field_t new_theta;  // Theta in whole degrees

    assign hit       = scan_valid && (acc_votes >= vote_t'(`HOUGH_VOTE_THRESHOLD));
    assign has_room  = (line_count < line_field_t'(`HOUGH_MAX_LINES));
    assign wr_idx    = line_count[$clog2(`HOUGH_MAX_LINES)-1:0];
    assign new_votes = line_field_t'(acc_votes);

    // theta_idx*180/16, truncated
    assign new_theta = line_field_t'((32'(scan_theta) * `HOUGH_THETA_SPAN) / `HOUGH_THETA_BINS);

    // Strict compare so the first minimum wins
    always_comb begin
        min_idx = '0;
        for (int i = 1; i < `HOUGH_MAX_LINES; i++) begin
            if (line_votes[i] < line_votes[min_idx]) begin
                min_idx = i[$clog2(`HOUGH_MAX_LINES)-1:0];
            end
        end
    end

    assign beats_min = (new_votes > line_votes[min_idx]);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            line_count <= '0;
            for (int i = 0; i < `HOUGH_MAX_LINES; i++) begin
                line_rho[i]   <= '0;
                line_theta[i] <= '0;
                line_votes[i] <= '0;
            end
        end else if (track_clear) begin
            line_count <= '0;   // No stale lines from the last run
            for (int i = 0; i < `HOUGH_MAX_LINES; i++) begin
                line_rho[i]   <= '0;
                line_theta[i] <= '0;
                line_votes[i] <= '0;
            end
        end else if (hit) begin
            if (has_room) begin
                // Append
                line_rho[wr_idx]   <= line_field_t'(scan_rho);
                line_theta[wr_idx] <= new_theta;
                line_votes[wr_idx] <= new_votes;
                line_count         <= line_count + 1'b1;
            end else if (beats_min) begin
                line_rho[min_idx]   <= line_field_t'(scan_rho);   // Evict the weakest
                line_theta[min_idx] <= new_theta;
                line_votes[min_idx] <= new_votes;
            end
        end
    end

endmodule

//--- design/hough_accumulator.sv
// 256-cell vote store with no reset; contents are only valid after a full clear sweep
`include "hough_params.svh"

module hough_accumulator (
    input  logic                 clk,
    input  hough_pkg::acc_addr_t acc_addr,
    input  logic                 acc_clear,   // Zero the addressed cell
    input  logic                 acc_incr,    // Add one vote to the addressed cell
    output hough_pkg::vote_t     acc_votes
);

    import hough_pkg::*;

    vote_t acc_mem [`HOUGH_ACC_CELLS];
    vote_t cur_votes;
    logic  at_max;

    // Read is combinational, shared by the increment and the scan
    assign cur_votes = acc_mem[acc_addr];
    assign at_max    = (cur_votes == vote_t'(`HOUGH_VOTE_MAX));

    always_ff @(posedge clk) begin
        if (acc_clear) begin
            acc_mem[acc_addr] <= '0;
        end else if (acc_incr && !at_max) begin
            acc_mem[acc_addr] <= cur_votes + 1'b1;   // Sticks at the ceiling
        end
    end

    assign acc_votes = cur_votes;

endmodule

//--- design/rho_binner.sv
// Combinational rho for one pixel and theta step; table is fixed at 16 steps and bins saturate to 0..15
`include "hough_params.svh"

module rho_binner (
    input  hough_pkg::coord_t     pixel_x,
    input  hough_pkg::coord_t     pixel_y,
    input  hough_pkg::theta_idx_t theta_idx,
    output hough_pkg::rho_bin_t   rho_bin
);

    import hough_pkg::*;

    logic signed [15:0] sin_val;   // sin(theta) * 256
    logic signed [15:0] cos_val;   // cos(theta) * 256
    logic signed [15:0] prod_x;
    logic signed [15:0] prod_y;
    logic signed [15:0] rho_sum;   // Scaled rho, fits easily in 16 bits
    logic signed [15:0] rho_raw;

    // Trig lookup, step is 11.25 degrees
    always_comb begin
        case (theta_idx)
            4'd0:    begin sin_val = 16'sd0;   cos_val = 16'sd256;  end  // 0
            4'd1:    begin sin_val = 16'sd50;  cos_val = 16'sd251;  end  // 11.25
            4'd2:    begin sin_val = 16'sd98;  cos_val = 16'sd237;  end  // 22.5
            4'd3:    begin sin_val = 16'sd142; cos_val = 16'sd213;  end  // 33.75
            4'd4:    begin sin_val = 16'sd181; cos_val = 16'sd181;  end  // 45
            4'd5:    begin sin_val = 16'sd213; cos_val = 16'sd142;  end  // 56.25
            4'd6:    begin sin_val = 16'sd237; cos_val = 16'sd98;   end  // 67.5
            4'd7:    begin sin_val = 16'sd251; cos_val = 16'sd50;   end  // 78.75
            4'd8:    begin sin_val = 16'sd256; cos_val = 16'sd0;    end  // 90
            4'd9:    begin sin_val = 16'sd251; cos_val = -16'sd50;  end  // 101.25
            4'd10:   begin sin_val = 16'sd237; cos_val = -16'sd98;  end  // 112.5
            4'd11:   begin sin_val = 16'sd213; cos_val = -16'sd142; end  // 123.75
            4'd12:   begin sin_val = 16'sd181; cos_val = -16'sd181; end  // 135
            4'd13:   begin sin_val = 16'sd142; cos_val = -16'sd213; end  // 146.25
            4'd14:   begin sin_val = 16'sd98;  cos_val = -16'sd237; end  // 157.5
            default: begin sin_val = 16'sd50;  cos_val = -16'sd251; end  // 168.75
        endcase
    end

    always_comb begin
        // Zero-extend the coordinates so the products stay signed
        prod_x  = $signed({1'b0, pixel_x}) * cos_val;
        prod_y  = $signed({1'b0, pixel_y}) * sin_val;
        rho_sum = prod_x + prod_y;
        rho_raw = rho_sum / (16'sd1 <<< `HOUGH_TRIG_SHIFT);  // Signed divide, rounds toward zero

        // Clamp into the bin range
        if (rho_raw < 0) begin
            rho_bin = '0;
        end else if (rho_raw >= `HOUGH_RHO_BINS) begin
            rho_bin = rho_bin_t'(`HOUGH_RHO_BINS - 1);
        end else begin
            rho_bin = rho_bin_t'(rho_raw);
        end
    end

endmodule

//--- design/edge_image_buffer.sv
// Byte-write image store; writes at address 32 or above are dropped and writes during a run are not supported
`include "hough_params.svh"

module edge_image_buffer (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               wr_en,      // One-cycle write strobe
    input  logic [7:0]         wr_addr,
    input  logic [7:0]         wr_data,    // Eight packed pixels
    input  hough_pkg::coord_t  pixel_x,
    input  hough_pkg::coord_t  pixel_y,
    output logic               edge_bit
);

    logic [7:0] img_mem [`HOUGH_IMG_BYTES];
    logic [7:0] pix_idx;     // Linear index y*16+x
    logic       wr_ok;

    // Out-of-range bytes are silently ignored
    assign wr_ok = wr_en && (wr_addr < 8'(`HOUGH_IMG_BYTES));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `HOUGH_IMG_BYTES; i++) begin
                img_mem[i] <= '0;   // Image starts blank
            end
        end else if (wr_ok) begin
            img_mem[wr_addr[4:0]] <= wr_data;
        end
    end

    // Row-major index, side is 16 so y lands in the upper nibble
    assign pix_idx = {pixel_y, pixel_x};

    // Upper five bits pick the byte, lower three the bit
    assign edge_bit = img_mem[pix_idx[7:3]][pix_idx[2:0]];

endmodule

//--- design/hough_pkg.sv
// Shared types for the Hough core; widths follow the size macros and assume power-of-two sizes
`include "hough_params.svh"

package hough_pkg;

    // Run phases of the sequencer
    typedef enum logic [2:0] {
        IDLE,
        CLEAR_ACC,     // Zero every accumulator cell
        VOTE,          // One pixel-theta pair per cycle
        FIND_PEAKS,    // One accumulator cell per cycle
        DONE_STATE
    } hough_state_t;

    typedef logic [$clog2(`HOUGH_IMG_SIZE)-1:0]   coord_t;      // Pixel x or y
    typedef logic [$clog2(`HOUGH_THETA_BINS)-1:0] theta_idx_t;  // Theta step
    typedef logic [$clog2(`HOUGH_RHO_BINS)-1:0]   rho_bin_t;    // Saturated rho bin

    // Vote count, wide enough to hold the ceiling
    typedef logic [$clog2(`HOUGH_VOTE_MAX+1)-1:0] vote_t;

    // Accumulator address is rho_bin*16+theta
    typedef logic [$clog2(`HOUGH_ACC_CELLS)-1:0]  acc_addr_t;

    typedef logic [7:0] line_field_t;  // Byte-wide result field

endpackage

//--- include/hough_params.svh
// Fixed sizes for the 16x16 Hough core; the RTL is hard-wired to these values and does not scale
`ifndef HOUGH_PARAMS_SVH
`define HOUGH_PARAMS_SVH

// Image geometry
`define HOUGH_IMG_SIZE 16          // Pixels per side
`define HOUGH_IMG_BYTES 32         // Eight pixels per byte, LSB first

// Hough space
`define HOUGH_RHO_BINS 16          // Rho bins after saturation
`define HOUGH_THETA_BINS 16        // Theta steps of 11.25 degrees
`define HOUGH_ACC_CELLS 256        // Rho bins times theta steps
`define HOUGH_THETA_SPAN 180       // Degrees covered by the theta steps

// Peak selection
`define HOUGH_MAX_LINES 4          // Result slots
`define HOUGH_VOTE_THRESHOLD 5     // Minimum votes for a slot

// Vote counter ceiling, counts stick here
`define HOUGH_VOTE_MAX 63

// Trig lookup is scaled by 2**shift
`define HOUGH_TRIG_SHIFT 8

`endif
